// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_spectrum
FILELIST  ?= src.f
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "No errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== bench/spectrum_golden.txt ====
// Per frame: 16 samples with x[0] first, 16 bins as {re, im} in bin order, then the peak index
// All values are two's complement hex
// Frame 0: DC level of 100
0064 0064 0064 0064 0064 0064 0064 0064
0064 0064 0064 0064 0064 0064 0064 0064
06400000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
0
// Frame 1: cosine at bin 4, amplitude 200
00C8 0000 FF38 0000 00C8 0000 FF38 0000
00C8 0000 FF38 0000 00C8 0000 FF38 0000
00000000 00000000 00000000 00000000 06400000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 06400000 00000000 00000000 00000000
4
// Frame 2: sine at bin 4, amplitude 100
0000 0064 0000 FF9C 0000 0064 0000 FF9C
0000 0064 0000 FF9C 0000 0064 0000 FF9C
00000000 00000000 00000000 00000000 0000FCE1 00000000 00000000 00000000
00000000 00000000 00000000 00000000 0000031F 00000000 00000000 00000000
4
// Frame 3: alternating -300 and 100
FED4 0064 FED4 0064 FED4 0064 FED4 0064
FED4 0064 FED4 0064 FED4 0064 FED4 0064
F9C10000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
F3810000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
8

// ==== bench/tb_spectrum.sv ====
module tb_spectrum
    import spectrum_pkg::*;
();

    localparam int n_frames    = 4;
    localparam int frame_words = 2 * n_points + 1;  // Samples, bins, peak index
    localparam int fft_latency = 5;                 // Cycles, counting the accepting edge's own
    localparam int done_delay  = 2;
    localparam int wait_limit  = 40;
    localparam int max_gap     = 3;

    logic      clk;
    logic      rst;
    logic      data_valid;
    sample_t   data;
    spectrum_t spectrum;
    logic      fft_valid;
    logic      done;
    index_t    freq;

    logic [31:0] golden [n_frames * frame_words];
    integer      seed;
    int unsigned tick;                    // Rising edges since time zero
    int unsigned accept_q [$];            // Edge that takes the last sample of each frame
    int          errors;
    int          checks;
    int          tests_run;
    int          tests_failed;
    int          errors_before;

    spectrum_top dut (
        .clk       (clk),
        .rst       (rst),
        .data_valid(data_valid),
        .data      (data),
        .spectrum  (spectrum),
        .fft_valid (fft_valid),
        .done      (done),
        .freq      (freq)
    );

    always #10 clk = ~clk;

    always @(posedge clk) tick <= tick + 1;

    task automatic compare_hex(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("** Error: %s expected %h, got %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic require(input bit ok, input string what);
        checks++;
        assert (ok) else begin
            $display("%s", what);
            errors++;
        end
    endtask

    task automatic check_quiet();
        compare_hex("fft_valid", 0, fft_valid);
        compare_hex("done", 0, done);
        compare_hex("freq", 0, freq);
    endtask

    task automatic send_frame(input int f, input int gaps);
        int gap;

        for (int n = 0; n < n_points; n++) begin
            @(posedge clk);
            data_valid <= 1'b1;
            data       <= sample_t'(golden[f * frame_words + n][15:0]);
            @(negedge clk);
            if (n == n_points - 1) begin
                accept_q.push_back(tick + 1);  // Taken on the next rising edge
            end else if (gaps > 0) begin
                gap = int'({$random(seed)} % (gaps + 1));
                repeat (gap) begin
                    @(posedge clk);
                    data_valid <= 1'b0;
                    data       <= sample_t'($random(seed));  // Junk must be ignored
                end
            end
        end
    endtask

    task automatic go_idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            data_valid <= 1'b0;
        end
    endtask

    task automatic wait_for_strobe(input bit want_done, output bit seen);
        seen = 1'b0;
        for (int c = 0; c < wait_limit && !seen; c++) begin
            @(negedge clk);
            seen = want_done ? done : fft_valid;
        end
    endtask

    task automatic check_frame(input int f);
        int          base;
        int unsigned accept_tick;
        bit          seen;

        base = f * frame_words;
        wait_for_strobe(1'b0, seen);
        require(seen, $sformatf("Timed out waiting for fft_valid of frame %0d", f));
        if (!seen) return;
        require(accept_q.size() > 0, "fft_valid came while no frame was pending");
        if (accept_q.size() == 0) return;
        accept_tick = accept_q.pop_front();
        compare_hex("fft_valid latency", fft_latency, tick - accept_tick + 1);
        for (int k = 0; k < n_points; k++) begin
            compare_hex($sformatf("spectrum[%0d]", k), golden[base + n_points + k], spectrum[k]);
        end
        @(negedge clk);
        compare_hex("fft_valid", 0, fft_valid);  // One cycle wide
        compare_hex("done", 0, done);            // Peak search still has a cycle to go
        wait_for_strobe(1'b1, seen);
        require(seen, $sformatf("Timed out waiting for done of frame %0d", f));
        if (!seen) return;
        compare_hex("done latency", fft_latency + done_delay, tick - accept_tick + 1);
        compare_hex("freq", golden[base + 2 * n_points], freq);
        @(negedge clk);
        compare_hex("done", 0, done);            // One cycle wide
    endtask

    task automatic close_test(input string name);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed, %0d errors", tests_run, name, errors - errors_before);
        end
        errors_before = errors;
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        data_valid = 1'b0;
        data       = '0;
        seed       = 14698;
        $readmemh("bench/spectrum_golden.txt", golden);

        repeat (9) begin
            @(negedge clk);
            check_quiet();
        end
        @(posedge clk);
        rst <= 1'b0;                           // Tenth edge still sees reset
        repeat (4) begin
            @(negedge clk);
            check_quiet();
        end
        close_test("reset");

        for (int f = 0; f < n_frames; f++) begin
            send_frame(f, 0);
            go_idle(1);
            check_frame(f);
        end
        close_test("frames without gaps");

        for (int f = 0; f < n_frames; f++) begin
            send_frame(f, max_gap);
            go_idle(1);
            check_frame(f);
        end
        close_test("frames with random gaps");

        fork
            begin
                for (int f = 0; f < n_frames; f++) begin
                    send_frame(f, 0);
                end
                go_idle(1);
            end
            begin
                for (int f = 0; f < n_frames; f++) begin
                    check_frame(f);
                end
            end
        join
        close_test("back to back frames");

        // Frames 1 and 2 put equal power in bins 4 and 12
        for (int f = 1; f <= 2; f++) begin
            send_frame(f, max_gap);
            go_idle(1);
            check_frame(f);
        end
        close_test("tie goes to lower bin");

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== common/spectrum_pkg.sv ====
package spectrum_pkg;

    localparam int n_points = 16;
    localparam int n_stages = 4;
    localparam int sample_w = 16;
    localparam int stage_w  = 32;
    localparam int bin_w    = 16;
    localparam int mag_w    = 32;
    localparam int prod_w   = 48;             // Twiddle product before Q16 rescale

    typedef logic [3:0] index_t;
    typedef logic signed [sample_w-1:0] sample_t;
    typedef sample_t [n_points-1:0] window_t;  // Index 0 holds the oldest sample

    typedef struct packed {
        logic signed [stage_w-1:0] re;
        logic signed [stage_w-1:0] im;
    } cplx_t;

    typedef cplx_t [n_points-1:0] stage_vec_t;

    typedef struct packed {
        logic signed [bin_w-1:0] re;
        logic signed [bin_w-1:0] im;
    } bin_t;

    typedef bin_t [n_points-1:0] spectrum_t;  // Natural bin order

    // W16^j = cos(2*pi*j/16) - i*sin(2*pi*j/16) in Q16
    localparam logic signed [stage_w-1:0] twiddle_re [n_points/2] = '{
        32'h0001_0000,                        // 1.0
        32'h0000_EC83,                        // 0.9239
        32'h0000_B504,                        // 0.7071
        32'h0000_61F7,                        // 0.3827
        32'h0000_0000,
        32'hFFFF_9E09,                        // -0.3827
        32'hFFFF_4AFC,                        // -0.7071
        32'hFFFF_137D                         // -0.9239
    };

    localparam logic signed [stage_w-1:0] twiddle_im [n_points/2] = '{
        32'h0000_0000,
        32'hFFFF_9E09,
        32'hFFFF_4AFC,
        32'hFFFF_137D,
        32'hFFFF_0000,                        // -1.0
        32'hFFFF_137D,
        32'hFFFF_4AFC,
        32'hFFFF_9E09
    };

    // Drop the Q16 fraction, nudging negative values up by one
    function automatic logic signed [stage_w-1:0] round_q16(
        input logic signed [prod_w-1:0] prod
    );
        return prod[prod_w-1:16] + {{(stage_w-1){1'b0}}, prod[prod_w-1]};
    endfunction

    // Stage values carry 8 fraction bits on top of the sample scale
    function automatic logic signed [bin_w-1:0] to_bin(
        input logic signed [stage_w-1:0] value
    );
        return value[23:8] + {{(bin_w-1){1'b0}}, value[stage_w-1]};
    endfunction

endpackage

// ==== fft/fft_pipeline.sv ====
module fft_pipeline
    import spectrum_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  window_t   window,
    output spectrum_t spectrum
);

    stage_vec_t link [n_stages+1];            // Stage inputs, last entry is stage 3 output

    always_comb begin
        for (int k = 0; k < n_points; k++) begin
            // Sign extend and add 8 fraction bits
            link[0][k].re = {{8{window[k][sample_w-1]}}, window[k], 8'h00};
            link[0][k].im = '0;
        end
    end

    for (genvar s = 0; s < n_stages; s++) begin : g_stage
        fft_stage #(
            .stage(s)
        ) u_stage (
            .clk (clk),
            .rst (rst),
            .din (link[s]),
            .dout(link[s+1])
        );
    end

    // DIF leaves bins in bit-reversed order
    always_comb begin
        index_t idx;
        index_t rev;

        for (int k = 0; k < n_points; k++) begin
            idx = index_t'(k);
            rev = {idx[0], idx[1], idx[2], idx[3]};
            spectrum[k].re = to_bin(link[n_stages][rev].re);
            spectrum[k].im = to_bin(link[n_stages][rev].im);
        end
    end

endmodule

// ==== fft/fft_stage.sv ====
module fft_stage
    import spectrum_pkg::*;
#(
    parameter int stage = 0
) (
    input  logic       clk,
    input  logic       rst,
    input  stage_vec_t din,
    output stage_vec_t dout
);

    stage_vec_t nxt;

    // Decimation in frequency: groups shrink by half each stage
    always_comb begin
        int a;
        int b;
        int tw;
        cplx_t diff;
        logic signed [prod_w-1:0] prod_re;
        logic signed [prod_w-1:0] prod_im;

        nxt = '0;
        for (int g = 0; g < (1 << stage); g++) begin
            for (int j = 0; j < (n_points >> (stage + 1)); j++) begin
                a  = g * (n_points >> stage) + j;
                b  = a + (n_points >> (stage + 1));
                tw = j << stage;              // Twiddle stride doubles per stage

                nxt[a].re = din[a].re + din[b].re;
                nxt[a].im = din[a].im + din[b].im;

                diff.re = din[a].re - din[b].re;
                diff.im = din[a].im - din[b].im;

                // Complex multiply, both products summed before rounding
                prod_re = diff.re * twiddle_re[tw] - diff.im * twiddle_im[tw];
                prod_im = diff.re * twiddle_im[tw] + diff.im * twiddle_re[tw];

                nxt[b].re = round_q16(prod_re);
                nxt[b].im = round_q16(prod_im);
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dout <= '0;
        end else begin
            dout <= nxt;
        end
    end

endmodule

// ==== logic/frame_control.sv ====
module frame_control
    import spectrum_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic data_valid,
    output logic fft_valid,
    output logic done
);

    index_t            count;                 // Samples accepted in current frame
    logic              frame_end;
    logic [n_stages:0] fft_chain;             // Window plus one bit per FFT stage
    logic [1:0]        peak_chain;            // Magnitude and argmax registers

    assign frame_end = data_valid && (count == index_t'(n_points - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= '0;
        end else if (data_valid) begin
            count <= count + 1'b1;            // Wraps at the frame size
        end
    end

    // Several frames may be in flight, so this is a shift chain and not a counter
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fft_chain  <= '0;
            peak_chain <= '0;
        end else begin
            fft_chain  <= {fft_chain[n_stages-1:0], frame_end};
            peak_chain <= {peak_chain[0], fft_chain[n_stages]};
        end
    end

    assign fft_valid = fft_chain[n_stages];
    assign done      = peak_chain[1];

endmodule

// ==== logic/peak_detect.sv ====
module peak_detect
    import spectrum_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  spectrum_t spectrum,
    output index_t    freq
);

    typedef struct packed {
        logic [mag_w-1:0] mag;
        index_t           idx;
    } cand_t;

    logic [mag_w-1:0] mag [n_points];
    logic [mag_w-1:0] mag_nxt [n_points];
    cand_t            node [2*n_points-1];    // Heap order, leaves hold bins 0 to 15

    always_comb begin
        logic signed [mag_w-1:0] sq_re;
        logic signed [mag_w-1:0] sq_im;

        for (int k = 0; k < n_points; k++) begin
            sq_re      = spectrum[k].re * spectrum[k].re;
            sq_im      = spectrum[k].im * spectrum[k].im;
            mag_nxt[k] = unsigned'(sq_re) + unsigned'(sq_im);  // Both terms non-negative
        end
    end

    always_comb begin
        for (int k = 0; k < n_points; k++) begin
            node[n_points-1+k] = '{mag: mag[k], idx: index_t'(k)};
        end
        // Left child covers lower bins, so >= keeps the lower index on a tie
        for (int i = n_points - 2; i >= 0; i--) begin
            node[i] = (node[2*i+1].mag >= node[2*i+2].mag) ? node[2*i+1] : node[2*i+2];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int k = 0; k < n_points; k++) begin
                mag[k] <= '0;
            end
            freq <= '0;
        end else begin
            mag  <= mag_nxt;
            freq <= node[0].idx;
        end
    end

endmodule

// ==== logic/sample_window.sv ====
module sample_window
    import spectrum_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    data_valid,
    input  sample_t data,
    output window_t window
);

    // Serial in at the top, oldest sample drops out of slot 0
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            window <= '0;
        end else if (data_valid) begin
            window <= {data, window[n_points-1:1]};  // Idle cycles leave the frame alone
        end
    end

endmodule

// ==== logic/spectrum_top.sv ====
module spectrum_top
    import spectrum_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      data_valid,
    input  sample_t   data,
    output spectrum_t spectrum,
    output logic      fft_valid,
    output logic      done,
    output index_t    freq
);

    window_t window;

    sample_window u_window (
        .clk       (clk),
        .rst       (rst),
        .data_valid(data_valid),
        .data      (data),
        .window    (window)
    );

    frame_control u_control (
        .clk       (clk),
        .rst       (rst),
        .data_valid(data_valid),
        .fft_valid (fft_valid),
        .done      (done)
    );

    fft_pipeline u_fft (
        .clk     (clk),
        .rst     (rst),
        .window  (window),
        .spectrum(spectrum)
    );

    peak_detect u_peak (
        .clk     (clk),
        .rst     (rst),
        .spectrum(spectrum),
        .freq    (freq)
    );

endmodule

// ==== src.f ====
common/spectrum_pkg.sv
logic/sample_window.sv
logic/frame_control.sv
fft/fft_stage.sv
fft/fft_pipeline.sv
logic/peak_detect.sv
logic/spectrum_top.sv
bench/tb_spectrum.sv
